// File: verilog/issue_defs.svh
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// queue geometry.
//////////////////////////////////////////////////////////////////////

`define IQ_DEPTH 8

// datapath widths.
`define INST_WIDTH 32
`define ADDR_WIDTH 32
`define ID_WIDTH   8

// instruction fields.
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB     25
`define RS_LSB     21
`define RT_MSB     20
`define RT_LSB     16
`define RD_MSB     15
`define RD_LSB     11

`endif

// File: verilog/isa_pkg.sv
`default_nettype none

`include "issue_defs.svh"

package isa_pkg;

  // top two bits give the class.
  typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
    NOP  = 6'b00_0000,
    ADD  = 6'b00_0001,
    SUB  = 6'b00_0010,
    ADDI = 6'b01_0000,
    SUBI = 6'b01_0001,
    LW   = 6'b10_0000,
    SW   = 6'b10_0001,
    JMP  = 6'b11_0000,
    BEQ  = 6'b11_0001
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_REG = 2'b00,
    ALU_IMM = 2'b01,
    MEM     = 2'b10, // loads and stores.
    BRANCH  = 2'b11
  } op_class_e;

  typedef logic [`RS_MSB-`RS_LSB:0] reg_idx_t;

endpackage

`default_nettype wire

// File: verilog/iq_pkg.sv
`default_nettype none

`include "issue_defs.svh"

package iq_pkg;

  // queue position where 0 is oldest.
  typedef logic [$clog2(`IQ_DEPTH)-1:0] iq_key_t;

  // free entries from 0 to depth inclusive.
  typedef logic [$clog2(`IQ_DEPTH+1)-1:0] iq_count_t;

  typedef enum logic {
    LANE_MEM    = 1'b0,
    LANE_BRANCH = 1'b1
  } lane_e;

endpackage

`default_nettype wire

// File: verilog/operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module operand_decode (
  input  wire [`INST_WIDTH-1:0] instruction,
  output isa_pkg::op_class_e    op_class,
  output isa_pkg::reg_idx_t     src0,
  output isa_pkg::reg_idx_t     src1,
  output isa_pkg::reg_idx_t     dest,
  output logic                  src0_vld,
  output logic                  src1_vld,
  output logic                  dest_vld
);

  isa_pkg::opcode_e opcode;

  assign opcode   = isa_pkg::opcode_e'(instruction[`OPCODE_MSB:`OPCODE_LSB]);
  assign op_class = isa_pkg::op_class_e'(instruction[`OPCODE_MSB -: 2]);
  assign src0     = instruction[`RS_MSB:`RS_LSB];
  assign src1     = instruction[`RT_MSB:`RT_LSB];

  always_comb begin
    src0_vld = 1'b0;
    src1_vld = 1'b0;
    dest_vld = 1'b0;
    dest     = instruction[`RD_MSB:`RD_LSB];
    case (op_class)
      isa_pkg::ALU_REG: begin
        src0_vld = (opcode != isa_pkg::NOP);
        src1_vld = (opcode != isa_pkg::NOP);
        dest_vld = (opcode != isa_pkg::NOP);
      end
      isa_pkg::ALU_IMM: begin
        src0_vld = 1'b1;
        dest     = instruction[`RT_MSB:`RT_LSB]; // rt is the target.
        dest_vld = 1'b1;
      end
      isa_pkg::MEM: begin
        src0_vld = (opcode == isa_pkg::LW) || (opcode == isa_pkg::SW); // base.
        src1_vld = (opcode == isa_pkg::SW);
        dest     = instruction[`RT_MSB:`RT_LSB];
        dest_vld = (opcode == isa_pkg::LW);
      end
      isa_pkg::BRANCH: ; // no registers.
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module issue_queue (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    flush,
  input  wire                    push0,
  input  wire                    push1,
  input  wire [`INST_WIDTH-1:0]  instruction0_in,
  input  wire [`INST_WIDTH-1:0]  instruction1_in,
  input  wire [`ADDR_WIDTH-1:0]  pc0_in,
  input  wire [`ADDR_WIDTH-1:0]  pc1_in,
  input  wire [`ID_WIDTH-1:0]    id0_in,
  input  wire [`ID_WIDTH-1:0]    id1_in,
  input  wire                    pick0,
  input  wire                    pick1,
  input  wire iq_pkg::iq_key_t   pick_key0,
  input  wire iq_pkg::iq_key_t   pick_key1,
  output logic [`IQ_DEPTH-1:0]   entry_vld,
  output logic [`INST_WIDTH-1:0] entry_instruction [`IQ_DEPTH],
  output logic [`ADDR_WIDTH-1:0] entry_pc [`IQ_DEPTH],
  output logic [`ID_WIDTH-1:0]   entry_id [`IQ_DEPTH],
  output iq_pkg::iq_count_t      free
);

  logic [`IQ_DEPTH-1:0]   remove;
  logic [`IQ_DEPTH-1:0]   vld_nxt;
  logic [`INST_WIDTH-1:0] inst_nxt [`IQ_DEPTH];
  logic [`ADDR_WIDTH-1:0] pc_nxt [`IQ_DEPTH];
  logic [`ID_WIDTH-1:0]   id_nxt [`IQ_DEPTH];
  iq_pkg::iq_count_t      slot;

  always_comb begin
    remove = '0;
    if (pick0)
      remove[pick_key0] = 1'b1;
    if (pick1)
      remove[pick_key1] = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // survivors slide toward key 0 and pushes land behind.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    vld_nxt  = '0;
    inst_nxt = entry_instruction;
    pc_nxt   = entry_pc;
    id_nxt   = entry_id;
    slot     = '0;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      if (entry_vld[i] && !remove[i]) begin
        vld_nxt[iq_pkg::iq_key_t'(slot)]  = 1'b1;
        inst_nxt[iq_pkg::iq_key_t'(slot)] = entry_instruction[i];
        pc_nxt[iq_pkg::iq_key_t'(slot)]   = entry_pc[i];
        id_nxt[iq_pkg::iq_key_t'(slot)]   = entry_id[i];
        slot = slot + 1'b1;
      end
    end
    if (push0 && slot < `IQ_DEPTH) begin
      vld_nxt[iq_pkg::iq_key_t'(slot)]  = 1'b1;
      inst_nxt[iq_pkg::iq_key_t'(slot)] = instruction0_in;
      pc_nxt[iq_pkg::iq_key_t'(slot)]   = pc0_in;
      id_nxt[iq_pkg::iq_key_t'(slot)]   = id0_in;
      slot = slot + 1'b1;
    end
    if (push1 && slot < `IQ_DEPTH) begin // younger than push0.
      vld_nxt[iq_pkg::iq_key_t'(slot)]  = 1'b1;
      inst_nxt[iq_pkg::iq_key_t'(slot)] = instruction1_in;
      pc_nxt[iq_pkg::iq_key_t'(slot)]   = pc1_in;
      id_nxt[iq_pkg::iq_key_t'(slot)]   = id1_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry_vld <= '0;
    end else if (flush) begin
      entry_vld <= '0; // drops this cycle's pushes too.
    end else begin
      entry_vld <= vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    entry_instruction <= inst_nxt;
    entry_pc          <= pc_nxt;
    entry_id          <= id_nxt;
  end

  assign free = iq_pkg::iq_count_t'(`IQ_DEPTH - $countones(entry_vld));

  // valid entries always form a run from key 0.
  a_vld_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
    ((entry_vld + 1'b1) & entry_vld) == '0);

  a_pick0_vld: assert property (@(posedge clk) disable iff (!rst_n)
    pick0 |-> entry_vld[pick_key0]);

  a_pick1_vld: assert property (@(posedge clk) disable iff (!rst_n)
    pick1 |-> entry_vld[pick_key1]);

endmodule

`default_nettype wire

// File: verilog/dual_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module dual_select (
  input  wire [`IQ_DEPTH-1:0]   entry_vld,
  input  wire [`INST_WIDTH-1:0] entry_instruction [`IQ_DEPTH],
  output logic                  pick0,
  output logic                  pick1,
  output iq_pkg::iq_key_t       pick_key0,
  output iq_pkg::iq_key_t       pick_key1,
  output logic                  swap
);

  isa_pkg::op_class_e   op_class [`IQ_DEPTH];
  isa_pkg::reg_idx_t    src0 [`IQ_DEPTH];
  isa_pkg::reg_idx_t    src1 [`IQ_DEPTH];
  isa_pkg::reg_idx_t    dest [`IQ_DEPTH];
  logic [`IQ_DEPTH-1:0] src0_vld;
  logic [`IQ_DEPTH-1:0] src1_vld;
  logic [`IQ_DEPTH-1:0] dest_vld;
  logic [`IQ_DEPTH-1:0] is_mem;
  logic [`IQ_DEPTH-1:0] is_branch;
  logic [`IQ_DEPTH-1:0] hard_haz [`IQ_DEPTH]; // blocks against any older entry.
  logic [`IQ_DEPTH-1:0] soft_haz [`IQ_DEPTH]; // waived when the older one is pick A.
  logic [`IQ_DEPTH-1:0] a_sel;
  logic [`IQ_DEPTH-1:0] b_mask;
  isa_pkg::op_class_e   a_class;
  iq_pkg::lane_e        a_lane;

  function automatic iq_pkg::iq_key_t first_key(input logic [`IQ_DEPTH-1:0] mask);
    iq_pkg::iq_key_t key;
    key = '0;
    for (int k = `IQ_DEPTH - 1; k >= 0; k--) begin
      if (mask[k])
        key = iq_pkg::iq_key_t'(k);
    end
    return key;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // per-entry decode and hazard matrix.
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `IQ_DEPTH; i++) begin : g_entry
    operand_decode i_decode (
      .instruction (entry_instruction[i]),
      .op_class    (op_class[i]),
      .src0        (src0[i]),
      .src1        (src1[i]),
      .dest        (dest[i]),
      .src0_vld    (src0_vld[i]),
      .src1_vld    (src1_vld[i]),
      .dest_vld    (dest_vld[i])
    );

    assign is_mem[i]    = (op_class[i] == isa_pkg::MEM);
    assign is_branch[i] = (op_class[i] == isa_pkg::BRANCH);
    assign a_sel[i]     = pick0 && (pick_key0 == iq_pkg::iq_key_t'(i));

    for (genvar j = 0; j < `IQ_DEPTH; j++) begin : g_older
      if (j < i) begin : g_pair
        logic raw;
        logic war;
        logic waw;
        assign raw = dest_vld[j] &&
                     ((src0_vld[i] && src0[i] == dest[j]) ||
                      (src1_vld[i] && src1[i] == dest[j]));
        assign war = dest_vld[i] &&
                     ((src0_vld[j] && src0[j] == dest[i]) ||
                      (src1_vld[j] && src1[j] == dest[i]));
        assign waw = dest_vld[i] && dest_vld[j] && dest[i] == dest[j];
        assign hard_haz[i][j] = entry_vld[j] && (raw || waw || (is_mem[i] && is_mem[j]));
        assign soft_haz[i][j] = entry_vld[j] && (war || is_branch[j]);
      end else begin : g_none
        assign hard_haz[i][j] = 1'b0;
        assign soft_haz[i][j] = 1'b0;
      end
    end

    // any entry but A, clear of hazards, not sharing A's pipe.
    assign b_mask[i] = entry_vld[i] && pick0 && !a_sel[i] &&
                       !(|hard_haz[i]) &&
                       !(|(soft_haz[i] & ~a_sel)) &&
                       !((op_class[i] == a_class) && (is_mem[i] || is_branch[i]));
  end

  //////////////////////////////////////////////////////////////////////
  // picks and steering.
  //////////////////////////////////////////////////////////////////////

  assign pick0     = |entry_vld;
  assign pick_key0 = first_key(entry_vld);
  assign a_class   = op_class[pick_key0];

  assign pick1     = |b_mask;
  assign pick_key1 = first_key(b_mask);

  assign a_lane = (a_class == isa_pkg::BRANCH || (pick1 && is_mem[pick_key1])) ?
                  iq_pkg::LANE_BRANCH : iq_pkg::LANE_MEM;
  assign swap   = pick0 && (a_lane == iq_pkg::LANE_BRANCH);

  always_comb begin
    if (pick0 && pick1) begin
      assert final (pick_key1 > pick_key0)
        else $error("second pick is not younger than the first");
    end
  end

endmodule

`default_nettype wire

// File: verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module issue_stage (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    flush,
  input  wire                    push0,
  input  wire                    push1,
  input  wire [`INST_WIDTH-1:0]  instruction0_in,
  input  wire [`INST_WIDTH-1:0]  instruction1_in,
  input  wire [`ADDR_WIDTH-1:0]  pc0_in,
  input  wire [`ADDR_WIDTH-1:0]  pc1_in,
  input  wire [`ID_WIDTH-1:0]    id0_in,
  input  wire [`ID_WIDTH-1:0]    id1_in,
  output logic                   stall,
  output iq_pkg::iq_count_t      free,
  output logic                   issue0_vld,
  output logic                   issue1_vld,
  output logic [`INST_WIDTH-1:0] instruction0_out,
  output logic [`INST_WIDTH-1:0] instruction1_out,
  output logic [`ADDR_WIDTH-1:0] pc0_out,
  output logic [`ADDR_WIDTH-1:0] pc1_out,
  output logic [`ID_WIDTH-1:0]   id0_out,
  output logic [`ID_WIDTH-1:0]   id1_out
);

  logic [`IQ_DEPTH-1:0]   entry_vld;
  logic [`INST_WIDTH-1:0] entry_instruction [`IQ_DEPTH];
  logic [`ADDR_WIDTH-1:0] entry_pc [`IQ_DEPTH];
  logic [`ID_WIDTH-1:0]   entry_id [`IQ_DEPTH];
  logic                   pick0;
  logic                   pick1;
  logic                   swap;
  iq_pkg::iq_key_t        pick_key0;
  iq_pkg::iq_key_t        pick_key1;
  iq_pkg::iq_key_t        lane0_key;
  iq_pkg::iq_key_t        lane1_key;
  logic                   lane0_vld;
  logic                   lane1_vld;

  issue_queue i_queue (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush             (flush),
    .push0             (push0),
    .push1             (push1),
    .instruction0_in   (instruction0_in),
    .instruction1_in   (instruction1_in),
    .pc0_in            (pc0_in),
    .pc1_in            (pc1_in),
    .id0_in            (id0_in),
    .id1_in            (id1_in),
    .pick0             (pick0),
    .pick1             (pick1),
    .pick_key0         (pick_key0),
    .pick_key1         (pick_key1),
    .entry_vld         (entry_vld),
    .entry_instruction (entry_instruction),
    .entry_pc          (entry_pc),
    .entry_id          (entry_id),
    .free              (free)
  );

  dual_select i_select (
    .entry_vld         (entry_vld),
    .entry_instruction (entry_instruction),
    .pick0             (pick0),
    .pick1             (pick1),
    .pick_key0         (pick_key0),
    .pick_key1         (pick_key1),
    .swap              (swap)
  );

  assign stall = (free < iq_pkg::iq_count_t'(2)); // room for a full pair.

  // swap puts pick A on the branch lane.
  assign lane0_key = swap ? pick_key1 : pick_key0;
  assign lane1_key = swap ? pick_key0 : pick_key1;
  assign lane0_vld = !flush && (swap ? pick1 : pick0);
  assign lane1_vld = !flush && (swap ? pick0 : pick1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue0_vld       <= 1'b0;
      issue1_vld       <= 1'b0;
      instruction0_out <= '0;
      instruction1_out <= '0;
      pc0_out          <= '0;
      pc1_out          <= '0;
      id0_out          <= '0;
      id1_out          <= '0;
    end else begin
      issue0_vld       <= lane0_vld;
      issue1_vld       <= lane1_vld;
      instruction0_out <= lane0_vld ? entry_instruction[lane0_key] : '0;
      instruction1_out <= lane1_vld ? entry_instruction[lane1_key] : '0;
      pc0_out          <= lane0_vld ? entry_pc[lane0_key] : '0;
      pc1_out          <= lane1_vld ? entry_pc[lane1_key] : '0;
      id0_out          <= lane0_vld ? entry_id[lane0_key] : '0;
      id1_out          <= lane1_vld ? entry_id[lane1_key] : '0;
    end
  end

  a_no_push_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |-> !(push0 || push1));

endmodule

`default_nettype wire

// File: dv/tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_defs.svh"

module tb_issue_stage;

  localparam int CLK_PERIOD      = 8;
  localparam int WATCHDOG_CYCLES = 400;

  logic                   clk;
  logic                   rst_n;
  logic                   flush;
  logic                   push0;
  logic                   push1;
  logic [`INST_WIDTH-1:0] instruction0_in;
  logic [`INST_WIDTH-1:0] instruction1_in;
  logic [`ADDR_WIDTH-1:0] pc0_in;
  logic [`ADDR_WIDTH-1:0] pc1_in;
  logic [`ID_WIDTH-1:0]   id0_in;
  logic [`ID_WIDTH-1:0]   id1_in;
  logic                   stall;
  iq_pkg::iq_count_t      free;
  logic                   issue0_vld;
  logic                   issue1_vld;
  logic [`INST_WIDTH-1:0] instruction0_out;
  logic [`INST_WIDTH-1:0] instruction1_out;
  logic [`ADDR_WIDTH-1:0] pc0_out;
  logic [`ADDR_WIDTH-1:0] pc1_out;
  logic [`ID_WIDTH-1:0]   id0_out;
  logic [`ID_WIDTH-1:0]   id1_out;

  // reference queue with index 0 oldest.
  logic [`INST_WIDTH-1:0] m_inst [`IQ_DEPTH];
  logic [`ADDR_WIDTH-1:0] m_pc [`IQ_DEPTH];
  logic [`ID_WIDTH-1:0]   m_id [`IQ_DEPTH];
  int                     m_cnt;
  logic                   exp_vld [2];
  logic [`INST_WIDTH-1:0] exp_inst [2];
  logic [`ADDR_WIDTH-1:0] exp_pc [2];
  logic [`ID_WIDTH-1:0]   exp_id [2];
  logic                   exp_swap;
  logic [31:0]            rng;
  int                     cyc;
  bit                     seen_stall;
  logic [`ID_WIDTH-1:0]   log_id [$];
  int                     log_lane [$];
  int                     log_cyc [$];

  issue_stage i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush            (flush),
    .push0            (push0),
    .push1            (push1),
    .instruction0_in  (instruction0_in),
    .instruction1_in  (instruction1_in),
    .pc0_in           (pc0_in),
    .pc1_in           (pc1_in),
    .id0_in           (id0_in),
    .id1_in           (id1_in),
    .stall            (stall),
    .free             (free),
    .issue0_vld       (issue0_vld),
    .issue1_vld       (issue1_vld),
    .instruction0_out (instruction0_out),
    .instruction1_out (instruction1_out),
    .pc0_out          (pc0_out),
    .pc1_out          (pc1_out),
    .id0_out          (id0_out),
    .id1_out          (id1_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $fatal(1);
  end

  //////////////////////////////////////////////////////////////////////
  // helpers and reference model.
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [`INST_WIDTH-1:0] encode(input isa_pkg::opcode_e op,
                                                    input int rs, input int rt, input int rd);
    logic [`INST_WIDTH-1:0] w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = op;
    w[`RS_MSB:`RS_LSB]         = 5'(rs);
    w[`RT_MSB:`RT_LSB]         = 5'(rt);
    w[`RD_MSB:`RD_LSB]         = 5'(rd);
    return w;
  endfunction

  function automatic isa_pkg::op_class_e class_of(input logic [`INST_WIDTH-1:0] inst);
    return isa_pkg::op_class_e'(inst[`OPCODE_MSB -: 2]);
  endfunction

  // -1 when nothing is written.
  function automatic int dest_of(input logic [`INST_WIDTH-1:0] inst);
    logic [5:0] op;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    case (class_of(inst))
      isa_pkg::ALU_REG: return (op != isa_pkg::NOP) ? int'(inst[`RD_MSB:`RD_LSB]) : -1;
      isa_pkg::ALU_IMM: return int'(inst[`RT_MSB:`RT_LSB]);
      isa_pkg::MEM:     return (op == isa_pkg::LW) ? int'(inst[`RT_MSB:`RT_LSB]) : -1;
      default:          return -1;
    endcase
  endfunction

  function automatic bit reads_reg(input logic [`INST_WIDTH-1:0] inst, input int r);
    logic [5:0] op;
    int         rs;
    int         rt;
    bit         hit;
    op  = inst[`OPCODE_MSB:`OPCODE_LSB];
    rs  = int'(inst[`RS_MSB:`RS_LSB]);
    rt  = int'(inst[`RT_MSB:`RT_LSB]);
    hit = 1'b0;
    case (class_of(inst))
      isa_pkg::ALU_REG: hit = (op != isa_pkg::NOP) && (rs == r || rt == r);
      isa_pkg::ALU_IMM: hit = (rs == r);
      isa_pkg::MEM:     hit = ((op == isa_pkg::LW || op == isa_pkg::SW) && rs == r) ||
                              (op == isa_pkg::SW && rt == r);
      default:          hit = 1'b0;
    endcase
    return (r >= 0) && hit;
  endfunction

  // oldest entry younger than A that clears every pairing check.
  function automatic int second_pick();
    bit ok;
    for (int i = 1; i < m_cnt; i++) begin
      ok = 1'b1;
      for (int j = 0; j < i; j++) begin
        if (reads_reg(m_inst[i], dest_of(m_inst[j])))
          ok = 1'b0;
        if (j > 0 && reads_reg(m_inst[j], dest_of(m_inst[i])))
          ok = 1'b0; // war is waived for A.
        if (dest_of(m_inst[i]) >= 0 && dest_of(m_inst[i]) == dest_of(m_inst[j]))
          ok = 1'b0;
        if (class_of(m_inst[i]) == isa_pkg::MEM && class_of(m_inst[j]) == isa_pkg::MEM)
          ok = 1'b0;
        if (j > 0 && class_of(m_inst[j]) == isa_pkg::BRANCH)
          ok = 1'b0;
      end
      if (class_of(m_inst[i]) inside {isa_pkg::MEM, isa_pkg::BRANCH} &&
          class_of(m_inst[i]) == class_of(m_inst[0]))
        ok = 1'b0;
      if (ok)
        return i;
    end
    return -1;
  endfunction

  // checks last edge's outputs, drives inputs and advances the model.
  task automatic step(input logic p0, input logic [`INST_WIDTH-1:0] i0,
                      input logic [`ID_WIDTH-1:0] d0, input logic p1,
                      input logic [`INST_WIDTH-1:0] i1, input logic [`ID_WIDTH-1:0] d1,
                      input logic fl, output logic took);
    int                     a;
    int                     b;
    int                     l;
    int                     n;
    int                     lane_idx [2];
    logic [`INST_WIDTH-1:0] k_inst [`IQ_DEPTH];
    logic [`ADDR_WIDTH-1:0] k_pc [`IQ_DEPTH];
    logic [`ID_WIDTH-1:0]   k_id [`IQ_DEPTH];
    logic [`ADDR_WIDTH-1:0] pc_a;
    logic [`ADDR_WIDTH-1:0] pc_b;
    @(negedge clk);
    cyc++;
    assert (issue0_vld === exp_vld[0] && instruction0_out === exp_inst[0] &&
            pc0_out === exp_pc[0] && id0_out === exp_id[0])
      else abort_run($sformatf("FAIL %0t: lane 0 vld %b id %0d pc %h, expected vld %b id %0d pc %h",
                               $time, issue0_vld, id0_out, pc0_out, exp_vld[0], exp_id[0],
                               exp_pc[0]));
    assert (issue1_vld === exp_vld[1] && instruction1_out === exp_inst[1] &&
            pc1_out === exp_pc[1] && id1_out === exp_id[1])
      else abort_run($sformatf("FAIL %0t: lane 1 vld %b id %0d pc %h, expected vld %b id %0d pc %h",
                               $time, issue1_vld, id1_out, pc1_out, exp_vld[1], exp_id[1],
                               exp_pc[1]));
    assert (free === iq_pkg::iq_count_t'(`IQ_DEPTH - m_cnt) &&
            stall === (m_cnt > `IQ_DEPTH - 2))
      else abort_run($sformatf("FAIL %0t: free %0d stall %b, expected free %0d",
                               $time, free, stall, `IQ_DEPTH - m_cnt));
    if (stall)
      seen_stall = 1'b1;
    for (int k = 0; k < 2; k++) begin
      l = exp_swap ? 1 - k : k; // older of the pair first.
      if (l == 0 ? issue0_vld : issue1_vld) begin
        log_id.push_back(l == 0 ? id0_out : id1_out);
        log_lane.push_back(l);
        log_cyc.push_back(cyc);
      end
    end

    took = p0 && !stall;
    rng  = xorshift(rng);
    pc_a = rng;
    rng  = xorshift(rng);
    pc_b = rng;
    push0           = took;
    push1           = took && p1;
    instruction0_in = i0;
    instruction1_in = i1;
    pc0_in          = pc_a;
    pc1_in          = pc_b;
    id0_in          = d0;
    id1_in          = d1;
    flush           = fl;

    a        = (m_cnt > 0) ? 0 : -1;
    b        = second_pick();
    exp_swap = (a >= 0) && (class_of(m_inst[0]) == isa_pkg::BRANCH ||
                            (b >= 0 && class_of(m_inst[b]) == isa_pkg::MEM));
    lane_idx[0] = exp_swap ? b : a;
    lane_idx[1] = exp_swap ? a : b;
    for (int k = 0; k < 2; k++) begin
      exp_vld[k]  = !fl && lane_idx[k] >= 0;
      exp_inst[k] = exp_vld[k] ? m_inst[lane_idx[k]] : '0;
      exp_pc[k]   = exp_vld[k] ? m_pc[lane_idx[k]] : '0;
      exp_id[k]   = exp_vld[k] ? m_id[lane_idx[k]] : '0;
    end
    n = 0;
    for (int i = 0; i < m_cnt; i++) begin
      if (i != a && i != b) begin
        k_inst[n] = m_inst[i];
        k_pc[n]   = m_pc[i];
        k_id[n]   = m_id[i];
        n++;
      end
    end
    if (push0) begin
      k_inst[n] = i0;
      k_pc[n]   = pc_a;
      k_id[n]   = d0;
      n++;
    end
    if (push1) begin
      k_inst[n] = i1;
      k_pc[n]   = pc_b;
      k_id[n]   = d1;
      n++;
    end
    if (fl)
      n = 0;
    m_inst = k_inst;
    m_pc   = k_pc;
    m_id   = k_id;
    m_cnt  = n;
  endtask

  task automatic idle();
    logic t;
    step(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, t);
  endtask

  task automatic wait_issued(input int total);
    int guard;
    guard = 0;
    while (log_id.size() < total) begin
      idle();
      guard++;
      assert (guard < 40) else abort_run("instructions did not issue within 40 cycles");
    end
  endtask

  // push a pair, wait for both, check order, lanes and pairing.
  task automatic pair_case(input logic [`INST_WIDTH-1:0] inst_a, input int id_a,
                           input logic [`INST_WIDTH-1:0] inst_b, input int id_b,
                           input int lane_a, input int lane_b, input bit together,
                           input string what);
    int   mark;
    logic t;
    mark = log_id.size();
    step(1'b1, inst_a, 8'(id_a), 1'b1, inst_b, 8'(id_b), 1'b0, t);
    wait_issued(mark + 2);
    assert (log_id[mark] == id_a && log_id[mark+1] == id_b &&
            log_lane[mark] == lane_a && log_lane[mark+1] == lane_b &&
            (log_cyc[mark] == log_cyc[mark+1]) == together)
      else abort_run($sformatf("FAIL %0t: %s gave ids %0d/%0d lanes %0d/%0d cycles %0d/%0d",
                               $time, what, log_id[mark], log_id[mark+1], log_lane[mark],
                               log_lane[mark+1], log_cyc[mark], log_cyc[mark+1]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests.
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    idle();
    assert (issue0_vld === 1'b0 && issue1_vld === 1'b0 &&
            free === iq_pkg::iq_count_t'(`IQ_DEPTH) && stall === 1'b0)
      else abort_run($sformatf("FAIL %0t: after reset free %0d stall %b", $time, free, stall));
  endtask

  task automatic alu_pair();
    pair_case(encode(isa_pkg::ADD, 1, 2, 3), 1, encode(isa_pkg::SUB, 4, 5, 6), 2,
              0, 1, 1'b1, "independent alu pair");
  endtask

  task automatic reg_hazards();
    pair_case(encode(isa_pkg::ADD, 1, 2, 3), 3, encode(isa_pkg::SUB, 3, 4, 5), 4,
              0, 0, 1'b0, "raw pair");
    pair_case(encode(isa_pkg::ADD, 1, 2, 7), 5, encode(isa_pkg::SUB, 4, 5, 7), 6,
              0, 0, 1'b0, "waw pair");
  endtask

  task automatic pipe_steering();
    pair_case(encode(isa_pkg::LW, 2, 1, 0), 7, encode(isa_pkg::LW, 4, 3, 0), 8,
              0, 0, 1'b0, "two loads");
    pair_case(encode(isa_pkg::BEQ, 1, 2, 0), 9, encode(isa_pkg::LW, 5, 6, 0), 10,
              1, 0, 1'b1, "branch then load");
    pair_case(encode(isa_pkg::BEQ, 1, 2, 0), 11, encode(isa_pkg::BEQ, 3, 4, 0), 12,
              1, 1, 1'b0, "two branches");
  endtask

  // branches drain one per cycle, so two pushes per cycle fill the queue.
  task automatic queue_fill();
    int   mark;
    int   next;
    int   guard;
    logic t;
    mark       = log_id.size();
    next       = 100;
    guard      = 0;
    seen_stall = 1'b0;
    while (next < 116) begin
      step(1'b1, encode(isa_pkg::BEQ, 0, 0, 0), 8'(next),
           1'b1, encode(isa_pkg::BEQ, 0, 0, 0), 8'(next + 1), 1'b0, t);
      if (t)
        next += 2;
      guard++;
      assert (guard < 60) else abort_run("queue did not accept all branch pushes");
    end
    wait_issued(mark + 16);
    assert (seen_stall) else abort_run("stall never rose while the queue filled");
    for (int k = 0; k < 16; k++) begin
      assert (log_id[mark+k] == 100 + k)
        else abort_run($sformatf("FAIL %0t: issue %0d of the chain was id %0d",
                                 $time, k, log_id[mark+k]));
    end
    idle();
    assert (log_id.size() == mark + 16 && free === iq_pkg::iq_count_t'(`IQ_DEPTH))
      else abort_run($sformatf("FAIL %0t: after the chain free %0d, %0d issues",
                               $time, free, log_id.size() - mark));
  endtask

  task automatic flush_queue();
    int   mark;
    logic t;
    step(1'b1, encode(isa_pkg::LW, 2, 1, 0), 8'd60, 1'b1, encode(isa_pkg::LW, 4, 3, 0), 8'd61,
         1'b0, t);
    step(1'b1, encode(isa_pkg::LW, 6, 5, 0), 8'd62, 1'b1, encode(isa_pkg::LW, 8, 7, 0), 8'd63,
         1'b0, t);
    step(1'b1, encode(isa_pkg::ADD, 1, 2, 9), 8'd64, 1'b1, encode(isa_pkg::ADD, 3, 4, 10),
         8'd65, 1'b1, t); // pushes here are dropped.
    mark = log_id.size();
    idle();
    assert (issue0_vld === 1'b0 && issue1_vld === 1'b0)
      else abort_run($sformatf("FAIL %0t: lane valid set after flush", $time));
    repeat (4) idle();
    assert (log_id.size() == mark && free === iq_pkg::iq_count_t'(`IQ_DEPTH))
      else abort_run($sformatf("FAIL %0t: after flush free %0d, %0d late issues",
                               $time, free, log_id.size() - mark));
  endtask

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    flush           = 1'b0;
    push0           = 1'b0;
    push1           = 1'b0;
    instruction0_in = '0;
    instruction1_in = '0;
    pc0_in          = '0;
    pc1_in          = '0;
    id0_in          = '0;
    id1_in          = '0;
    rng             = 32'h53cd2304;
    m_cnt           = 0;
    exp_swap        = 1'b0;
    cyc             = 0;
    seen_stall      = 1'b0;
    for (int k = 0; k < 2; k++) begin
      exp_vld[k]  = 1'b0;
      exp_inst[k] = '0;
      exp_pc[k]   = '0;
      exp_id[k]   = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_values();
    alu_pair();
    reg_hazards();
    pipe_steering();
    queue_fill();
    flush_queue();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/iq_pkg.sv
verilog/operand_decode.sv
verilog/issue_queue.sv
verilog/dual_select.sv
verilog/issue_stage.sv
dv/tb_issue_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_issue_stage -o tb_issue_stage_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build returned status $build_status"
  exit "$build_status"
fi

./obj_dir/tb_issue_stage_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
  echo "simulation returned status $run_status"
  exit "$run_status"
fi

exit 0
